// File: include/dcache_defines.svh
/*
  data cache parameters: widths and counts of the cache geometry and the burst RAM
*/
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address and data word
`define DC_ADDR_W 32
`define DC_WORD_W 32
`define DC_ALIGN_W 2

// cache geometry: 8 words per line, 2 lines
`define DC_WORD_IX_W 3
`define DC_LINE_IX_W 1

// burst RAM: 4 beats of 64 bits per line, 256 beats in all
`define DC_BEAT_W 64
`define DC_BEATS 4
`define DC_RAM_ADDR_W 8
`define DC_WORDS_PER_BEAT 2

// derived values
`define DC_TAG_W (`DC_ADDR_W - `DC_LINE_IX_W - `DC_WORD_IX_W - `DC_ALIGN_W)
`define DC_LINES (1 << `DC_LINE_IX_W)
`define DC_WORDS (1 << `DC_WORD_IX_W)
`define DC_BYTES_PER_WORD (`DC_WORD_W / 8)
`define DC_BEAT_IX_W $clog2(`DC_BEATS)
// byte address to RAM beat address
`define DC_BEAT_SHIFT (`DC_ALIGN_W + $clog2(`DC_WORDS_PER_BEAT))

`endif

// File: rtl/dcache_ctrl.sv
/*
  data cache controller: hit handling, dirty line write-back and line fill sequencing
*/
`include "dcache_defines.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  // core side
  input  logic         enable,
  input  cache_req_t   req,
  output logic         busy,
  output logic         data_out_ready,
  output word_t        data_out,
  // tag store
  input  logic         hit,
  input  logic         victim_dirty,
  input  ram_addr_t    victim_addr,
  output addr_fields_t cur,
  output logic         tag_fill,
  output logic         tag_dirty,
  // line store
  output byte_en_t     store_byte_we,
  output word_t        store_wdata,
  output logic         fill_we,
  output beat_ix_t     beat_ix,
  input  beat_t        rd_beat,
  input  word_t        rd_word,
  // burst RAM
  output logic         br_cmd_en,
  output ram_cmd_t     br_cmd,
  input  beat_t        br_rd_data,
  input  logic         br_rd_data_valid
);

  dc_state_e state;
  cache_req_t req_q;
  cache_req_t cur_req;
  beat_ix_t beat_cnt;
  addr_fields_t line_base;
  ram_addr_t fill_addr;
  word_t beat_word;
  logic is_write;
  logic accept;
  logic miss;
  logic wb_start;
  logic wb_done;
  logic rd_start;
  logic last_beat;
  logic word_in_beat;
  logic rd_hit;
  logic fill_rd;

  // live request while idle, captured copy for the rest of a miss
  assign cur_req = (state == idle) ? req : req_q;
  assign cur = addr_fields_t'(cur_req.addr);
  assign is_write = |cur_req.be;
  assign store_wdata = cur_req.wdata;

  assign accept = (state == idle) && enable;
  assign miss = accept && !hit;
  assign wb_start = miss && victim_dirty;
  // all four write beats are out once the counter wraps back to 0
  assign wb_done = (state == write_back) && (beat_cnt == '0);
  assign rd_start = (miss && !victim_dirty) || wb_done;

  // beat index shared by write-back reads and fill writes
  assign beat_ix = beat_cnt;
  assign fill_we = ((state == fill_wait) || (state == fill_data)) && br_rd_data_valid;
  assign last_beat = fill_we && (beat_cnt == beat_ix_t'(`DC_BEATS - 1));

  // requested word inside the arriving beat, even word in the low half
  assign word_in_beat = beat_cnt == beat_ix_t'(int'(cur.word) / `DC_WORDS_PER_BEAT);
  assign beat_word =
    br_rd_data[(int'(cur.word) % `DC_WORDS_PER_BEAT) * `DC_WORD_W +: `DC_WORD_W];

  assign rd_hit = accept && hit && !is_write;
  assign fill_rd = fill_we && word_in_beat && !is_write;

  // byte writes on a write hit, or merged with the last fill beat
  assign store_byte_we = ((accept && hit) || last_beat) ? cur_req.be : '0;
  assign tag_dirty = |store_byte_we;
  assign tag_fill = last_beat;

  // line base address of the request, in RAM beats
  always_comb begin
    line_base = cur;
    line_base.word = '0;
    line_base.zero = '0;
  end
  assign fill_addr = ram_addr_t'(addr_t'(line_base) >> `DC_BEAT_SHIFT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      busy <= 1'b0;
      data_out_ready <= 1'b0;
      br_cmd_en <= 1'b0;
      beat_cnt <= '0;
    end else begin
      // strobes last one cycle
      data_out_ready <= rd_hit || fill_rd;
      br_cmd_en <= wb_start || rd_start;
      if (miss) begin
        busy <= 1'b1;
      end else if (last_beat) begin
        busy <= 1'b0;
      end
      case (state)
        idle: begin
          if (miss) begin
            state <= victim_dirty ? write_back : fill_wait;
          end
          // beat 0 leaves with the write command
          if (wb_start) begin
            beat_cnt <= beat_ix_t'(1);
          end
        end
        write_back: begin
          if (wb_done) begin
            state <= fill_wait;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        fill_wait: begin
          if (fill_we) begin
            beat_cnt <= beat_cnt + 1'b1;
            state <= fill_data;
          end
        end
        fill_data: begin
          if (fill_we) begin
            // wraps to 0 on the last beat
            beat_cnt <= beat_cnt + 1'b1;
          end
          if (last_beat) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // request, response word and RAM command payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
    if (rd_hit) begin
      data_out <= rd_word;
    end else if (fill_rd) begin
      data_out <= beat_word;
    end
    if (wb_start) begin
      br_cmd.write <= 1'b1;
      br_cmd.addr <= victim_addr;
      br_cmd.wdata <= rd_beat;
    end else if (rd_start) begin
      br_cmd.write <= 1'b0;
      br_cmd.addr <= fill_addr;
    end else if (state == write_back) begin
      // beats 1 to 3 follow without a strobe
      br_cmd.wdata <= rd_beat;
    end
  end

endmodule

// File: rtl/dcache_line_store.sv
/*
  data cache line store: word array with byte-merge writes, beat fills and beat/word reads
*/
`include "dcache_defines.svh"

module dcache_line_store
  import dcache_pkg::*;
(
  input  logic         clk,
  input  addr_fields_t cur,
  // byte writes into the addressed word
  input  byte_en_t     store_byte_we,
  input  word_t        store_wdata,
  // beat writes during a fill
  input  logic         fill_we,
  input  beat_ix_t     beat_ix,
  input  beat_t        fill_beat,
  // reads
  output beat_t        rd_beat,
  output word_t        rd_word
);

  // one line as a packed array of words
  typedef logic [`DC_WORDS-1:0][`DC_WORD_W-1:0] line_t;

  line_t mem [`DC_LINES];
  line_t next_line;
  logic line_we;

  // next contents of the addressed line
  always_comb begin
    next_line = mem[cur.line];
    // received beat lands in adjacent words, even word from the low half
    if (fill_we) begin
      for (int k = 0; k < `DC_WORDS_PER_BEAT; k++) begin
        next_line[int'(beat_ix) * `DC_WORDS_PER_BEAT + k] =
          fill_beat[k * `DC_WORD_W +: `DC_WORD_W];
      end
    end
    // enabled bytes win over fill data in the same cycle
    for (int b = 0; b < `DC_BYTES_PER_WORD; b++) begin
      if (store_byte_we[b]) begin
        next_line[cur.word][b * 8 +: 8] = store_wdata[b * 8 +: 8];
      end
    end
  end

  assign line_we = fill_we || (|store_byte_we);

  always_ff @(posedge clk) begin
    if (line_we) begin
      mem[cur.line] <= next_line;
    end
  end

  // indexed beat for write-back
  always_comb begin
    for (int k = 0; k < `DC_WORDS_PER_BEAT; k++) begin
      rd_beat[k * `DC_WORD_W +: `DC_WORD_W] =
        mem[cur.line][int'(beat_ix) * `DC_WORDS_PER_BEAT + k];
    end
  end

  // addressed word for read hits
  assign rd_word = mem[cur.line][cur.word];

endmodule

// File: rtl/dcache_pkg.sv
/*
  data cache types: address fields, core request, RAM command and FSM states
*/
`include "dcache_defines.svh"

package dcache_pkg;

  // plain vectors with a meaning
  typedef logic [`DC_ADDR_W-1:0] addr_t;
  typedef logic [`DC_WORD_W-1:0] word_t;
  typedef logic [`DC_BEAT_W-1:0] beat_t;
  typedef logic [`DC_BYTES_PER_WORD-1:0] byte_en_t;
  typedef logic [`DC_TAG_W-1:0] tag_t;
  typedef logic [`DC_LINE_IX_W-1:0] line_ix_t;
  typedef logic [`DC_WORD_IX_W-1:0] word_ix_t;
  typedef logic [`DC_BEAT_IX_W-1:0] beat_ix_t;
  typedef logic [`DC_RAM_ADDR_W-1:0] ram_addr_t;

  // byte address split as |tag|line|word|00|
  typedef struct packed {
    tag_t tag;
    line_ix_t line;
    word_ix_t word;
    logic [`DC_ALIGN_W-1:0] zero;
  } addr_fields_t;

  // core request, a write when any byte enable is set
  typedef struct packed {
    addr_t addr;
    byte_en_t be;
    word_t wdata;
  } cache_req_t;

  // command to the burst RAM
  typedef struct packed {
    logic write;
    ram_addr_t addr;
    beat_t wdata;
  } ram_cmd_t;

  typedef enum logic [1:0] {
    idle,
    write_back,
    fill_wait,
    fill_data
  } dc_state_e;

endpackage

// File: rtl/dcache_tag_store.sv
/*
  data cache tag store: valid, dirty and tag per line, hit check and victim address
*/
`include "dcache_defines.svh"

module dcache_tag_store
  import dcache_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  addr_fields_t cur,
  input  logic         tag_fill,
  input  logic         tag_dirty,
  output logic         hit,
  output logic         victim_dirty,
  output ram_addr_t    victim_addr
);

  logic [`DC_LINES-1:0] valid;
  logic [`DC_LINES-1:0] dirty;
  tag_t tags [`DC_LINES];
  addr_fields_t victim;

  // line state, all invalid and clean out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else if (tag_fill) begin
      // refilled line, dirty only when a write merges into it
      valid[cur.line] <= 1'b1;
      dirty[cur.line] <= tag_dirty;
    end else if (tag_dirty) begin
      dirty[cur.line] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_fill) begin
      tags[cur.line] <= cur.tag;
    end
  end

  // lookup on the addressed line
  assign hit = valid[cur.line] && (tags[cur.line] == cur.tag);
  assign victim_dirty = valid[cur.line] && dirty[cur.line];

  // victim line base, rebuilt from the stored tag
  always_comb begin
    victim.tag = tags[cur.line];
    victim.line = cur.line;
    victim.word = '0;
    victim.zero = '0;
  end

  // beat 0 address of the victim in the RAM
  assign victim_addr = ram_addr_t'(addr_t'(victim) >> `DC_BEAT_SHIFT);

endmodule

// File: rtl/dcache_top.sv
/*
  direct-mapped write-back data cache in front of a four-beat burst RAM
*/
module dcache_top
  import dcache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // core port
  input  logic       enable,
  input  cache_req_t req,
  output logic       busy,
  output word_t      data_out,
  output logic       data_out_ready,
  // burst RAM port
  output logic       br_cmd_en,
  output ram_cmd_t   br_cmd,
  input  beat_t      br_rd_data,
  input  logic       br_rd_data_valid
);

  // controller to tag store
  addr_fields_t cur;
  logic hit;
  logic victim_dirty;
  ram_addr_t victim_addr;
  logic tag_fill;
  logic tag_dirty;
  // controller to line store
  byte_en_t store_byte_we;
  word_t store_wdata;
  logic fill_we;
  beat_ix_t beat_ix;
  beat_t rd_beat;
  word_t rd_word;

  dcache_ctrl dcache_ctrl_inst (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .req              (req),
    .busy             (busy),
    .data_out_ready   (data_out_ready),
    .data_out         (data_out),
    .hit              (hit),
    .victim_dirty     (victim_dirty),
    .victim_addr      (victim_addr),
    .cur              (cur),
    .tag_fill         (tag_fill),
    .tag_dirty        (tag_dirty),
    .store_byte_we    (store_byte_we),
    .store_wdata      (store_wdata),
    .fill_we          (fill_we),
    .beat_ix          (beat_ix),
    .rd_beat          (rd_beat),
    .rd_word          (rd_word),
    .br_cmd_en        (br_cmd_en),
    .br_cmd           (br_cmd),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  dcache_tag_store dcache_tag_store_inst (
    .clk          (clk),
    .rst          (rst),
    .cur          (cur),
    .tag_fill     (tag_fill),
    .tag_dirty    (tag_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_addr  (victim_addr)
  );

  // fill data comes straight from the RAM read bus
  dcache_line_store dcache_line_store_inst (
    .clk           (clk),
    .cur           (cur),
    .store_byte_we (store_byte_we),
    .store_wdata   (store_wdata),
    .fill_we       (fill_we),
    .beat_ix       (beat_ix),
    .fill_beat     (br_rd_data),
    .rd_beat       (rd_beat),
    .rd_word       (rd_word)
  );

endmodule

// File: tests/burst_ram_model.sv
/*
  burst RAM model: four-beat reads after a fixed latency, four-beat write capture
*/
`include "dcache_defines.svh"

module burst_ram_model
  import dcache_pkg::*;
#(
  parameter int read_latency = 3
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     cmd_en,
  input  ram_cmd_t cmd,
  output beat_t    rd_data,
  output logic     rd_data_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // beat storage, preloaded by the testbench
  beat_t mem [1 << `DC_RAM_ADDR_W];

  ram_addr_t rd_addr;
  logic rd_pending;
  int rd_delay;
  int rd_next;
  ram_addr_t wr_addr;
  int wr_left;

  always @(posedge clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
      rd_data_valid <= 1'b0;
      rd_data <= '0;
      rd_delay <= 0;
      rd_next <= 0;
      wr_left <= 0;
    end else begin
      // read command, beats come back read_latency cycles later
      if (cmd_en && !cmd.write) begin
        rd_pending <= 1'b1;
        rd_addr <= cmd.addr;
        rd_delay <= read_latency - 1;
      end else if (rd_pending) begin
        if (rd_delay > 1) begin
          rd_delay <= rd_delay - 1;
        end else begin
          rd_pending <= 1'b0;
          rd_data_valid <= 1'b1;
          rd_data <= mem[rd_addr];
          rd_next <= 1;
        end
      end
      // remaining beats on consecutive cycles
      if (rd_data_valid) begin
        if (rd_next == `DC_BEATS) begin
          rd_data_valid <= 1'b0;
        end else begin
          rd_data <= mem[rd_addr + ram_addr_t'(rd_next)];
          rd_next <= rd_next + 1;
        end
      end
      // write command carries beat 0, beats 1 to 3 follow without a strobe
      if (cmd_en && cmd.write) begin
        mem[cmd.addr] <= cmd.wdata;
        wr_addr <= cmd.addr + 1'b1;
        wr_left <= `DC_BEATS - 1;
      end else if (wr_left > 0) begin
        mem[wr_addr] <= cmd.wdata;
        wr_addr <= wr_addr + 1'b1;
        wr_left <= wr_left - 1;
      end
    end
  end

endmodule

// File: tests/dcache_assert.sv
/*
  data cache controller assertions on RAM strobes, response strobes and fill states
*/
module dcache_assert
  import dcache_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input dc_state_e  state,
  input logic       enable,
  input cache_req_t req,
  input logic       hit,
  input logic       data_out_ready,
  input logic       br_cmd_en,
  input logic       br_rd_data_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // read by the testbench at the end of the run
  int fail_count = 0;

  // commands are single-cycle pulses
  assert property (@(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en)
    else begin
      fail_count++;
      $error("br_cmd_en high for two cycles in a row");
    end

  // a write hit gives no response strobe
  assert property (@(posedge clk) disable iff (rst)
    (state == idle && enable && hit && (|req.be)) |=> !data_out_ready)
    else begin
      fail_count++;
      $error("data_out_ready pulsed after a write hit");
    end

  // fill_data is only reached on a received beat
  assert property (@(posedge clk) disable iff (rst)
    (state == fill_data) |-> $past(br_rd_data_valid))
    else begin
      fail_count++;
      $error("fill_data state without a beat in the previous cycle");
    end

endmodule

bind dcache_ctrl dcache_assert dcache_assert_inst (
  .clk              (clk),
  .rst              (rst),
  .state            (state),
  .enable           (enable),
  .req              (req),
  .hit              (hit),
  .data_out_ready   (data_out_ready),
  .br_cmd_en        (br_cmd_en),
  .br_rd_data_valid (br_rd_data_valid)
);

// File: tests/dcache_tb.sv
/*
  data cache testbench with directed hit, miss and eviction cases, then seeded random
  traffic checked against a mirror memory of the RAM contents
*/
`include "dcache_defines.svh"

module dcache_tb
  import dcache_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ram_beats = 1 << `DC_RAM_ADDR_W;
  localparam int mirror_words = ram_beats * `DC_WORDS_PER_BEAT;
  localparam int wait_limit = 100;

  logic clk;
  logic rst;
  logic enable;
  cache_req_t req;
  logic busy;
  word_t data_out;
  logic data_out_ready;
  logic br_cmd_en;
  ram_cmd_t br_cmd;
  beat_t br_rd_data;
  logic br_rd_data_valid;

  // expected memory contents with one entry per word
  word_t mirror [mirror_words];
  int n_checks = 0;
  int n_errors = 0;

  dcache_top dcache_top_inst (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .req              (req),
    .busy             (busy),
    .data_out         (data_out),
    .data_out_ready   (data_out_ready),
    .br_cmd_en        (br_cmd_en),
    .br_cmd           (br_cmd),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  burst_ram_model #(.read_latency(3)) burst_ram_inst (
    .clk           (clk),
    .rst           (rst),
    .cmd_en        (br_cmd_en),
    .cmd           (br_cmd),
    .rd_data       (br_rd_data),
    .rd_data_valid (br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // word-aligned random address below 2 KB
  function automatic addr_t rand_addr();
    return addr_t'($urandom_range(0, mirror_words - 1)) << `DC_ALIGN_W;
  endfunction

  function automatic byte_en_t rand_be();
    byte_en_t be;
    be = byte_en_t'($urandom);
    // at least one byte since no enable would make it a read
    if (be == '0) begin
      be = byte_en_t'(1);
    end
    return be;
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input byte_en_t be);
    word_t w;
    w = old_w;
    for (int b = 0; b < `DC_BYTES_PER_WORD; b++) begin
      if (be[b]) begin
        w[b * 8 +: 8] = new_w[b * 8 +: 8];
      end
    end
    return w;
  endfunction

  // random RAM contents copied into the mirror
  task automatic preload_ram();
    beat_t b;
    for (int i = 0; i < ram_beats; i++) begin
      b = {$urandom, $urandom};
      burst_ram_inst.mem[i] <= b;
      for (int k = 0; k < `DC_WORDS_PER_BEAT; k++) begin
        mirror[i * `DC_WORDS_PER_BEAT + k] = b[k * `DC_WORD_W +: `DC_WORD_W];
      end
    end
  endtask

  // one request cycle that returns right after the accepting edge
  task automatic issue(input addr_t a, input byte_en_t be, input word_t wd);
    @(posedge clk);
    enable <= 1'b1;
    req <= '{addr: a, be: be, wdata: wd};
    @(posedge clk);
    enable <= 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (busy && cycles < wait_limit);
    if (busy) begin
      n_errors++;
      $display("%s: busy did not fall within %0d cycles", name, wait_limit);
    end
  endtask

  task automatic read_check(input string name, input addr_t a, output logic saw_busy);
    int cycles;
    logic got;
    word_t data;
    cycles = 0;
    got = 1'b0;
    saw_busy = 1'b0;
    data = '0;
    issue(a, '0, '0);
    while (!got && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
      saw_busy |= busy;
      if (data_out_ready) begin
        got = 1'b1;
        data = data_out;
      end
    end
    if (!got) begin
      n_errors++;
      $display("%s: no data_out_ready within %0d cycles", name, wait_limit);
    end else begin
      check_word(name, mirror[a >> `DC_ALIGN_W], data);
    end
    wait_idle(name);
  endtask

  task automatic write_word(input string name, input addr_t a, input byte_en_t be,
                            input word_t wd);
    int idx;
    idx = a >> `DC_ALIGN_W;
    issue(a, be, wd);
    wait_idle(name);
    mirror[idx] = merge_bytes(mirror[idx], wd, be);
  endtask

  initial begin
    addr_t a;
    addr_fields_t f;
    addr_t b_addr;
    logic saw_busy;
    int base;
    int assert_fails;
    void'($urandom(32'h84b0f231));
    rst = 1'b1;
    enable = 1'b0;
    req = '0;
    preload_ram();
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // cold miss and then a hit on the same word
    a = rand_addr();
    read_check("read_miss", a, saw_busy);
    if (!saw_busy) begin
      n_errors++;
      $display("read_miss: busy stayed low on a read that should miss");
    end
    read_check("read_hit", a, saw_busy);
    if (saw_busy) begin
      n_errors++;
      $display("read_hit: busy went high on a read that should hit");
    end

    // byte-merge write and read back
    write_word("write_merge", a, rand_be(), $urandom);
    read_check("read_merge", a, saw_busy);

    // dirty line 0 evicted by another tag and then read back from RAM
    f = addr_fields_t'(rand_addr());
    f.line = '0;
    a = addr_t'(f);
    f.tag[0] = ~f.tag[0];
    f.word = word_ix_t'($urandom);
    b_addr = addr_t'(f);
    write_word("evict_write", a, rand_be(), $urandom);
    read_check("evict_other", b_addr, saw_busy);
    read_check("evict_reread", a, saw_busy);
    base = (a >> `DC_BEAT_SHIFT) & ~(`DC_BEATS - 1);
    for (int i = base; i < base + `DC_BEATS; i++) begin
      check_beat($sformatf("writeback_beat_%0d", i - base),
                 {mirror[2 * i + 1], mirror[2 * i]}, burst_ram_inst.mem[i]);
    end

    // random mix of reads and writes
    for (int n = 0; n < 400; n++) begin
      a = rand_addr();
      if ($urandom_range(0, 1) == 0) begin
        read_check($sformatf("random_read_%0d", n), a, saw_busy);
      end else begin
        write_word($sformatf("random_write_%0d", n), a, rand_be(), $urandom);
      end
    end

    repeat (2) @(posedge clk);
    assert_fails = dcache_top_inst.dcache_ctrl_inst.dcache_assert_inst.fail_count;
    $display("checks %0d errors %0d assertion failures %0d",
             n_checks, n_errors, assert_fails);
    if (n_errors == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_tag_store.sv
rtl/dcache_line_store.sv
rtl/dcache_top.sv
tests/burst_ram_model.sv
tests/dcache_assert.sv
tests/dcache_tb.sv
